//--- mem_subsys.f
design/mem_pkg.sv
design/dmem_if.sv
design/mem_stage.sv
design/data_ram.sv
design/wb_stage.sv
design/mem_subsys.sv
tests/mem_subsys_chk.sv
tests/tb_mem_subsys.sv

//--- tests/mem_cases.txt
// op pc addr store_data dest gr_we expected_retire_data (hex, ops 0 alu .. 8 st_w)
8 00000100 00000040 11223344 00 0 00000000
6 00000104 00000041 000000aa 00 0 00000000
6 00000108 00000043 ffffff80 00 0 00000000
5 0000010c 00000040 00000000 01 1 8022aa44
7 00000110 00000042 0000beef 00 0 00000000
7 00000114 00000040 12347f01 00 0 00000000
5 00000118 00000040 00000000 02 1 beef7f01
6 0000011c 00000040 0000005a 00 0 00000000
6 00000120 00000042 000000c3 00 0 00000000
5 00000124 00000040 00000000 03 1 bec37f5a
1 00000128 00000040 00000000 04 1 0000005a
1 0000012c 00000042 00000000 05 1 ffffffc3
2 00000130 00000043 00000000 06 1 000000be
2 00000134 00000041 00000000 07 1 0000007f
3 00000138 00000042 00000000 08 1 ffffbec3
3 0000013c 00000040 00000000 09 1 00007f5a
4 00000140 00000042 00000000 0a 1 0000bec3
0 00000144 0000abcd 00000000 0b 1 0000abcd
0 00000148 12345678 00000000 00 1 00000000
0 0000014c deadbeef 00000000 0c 1 deadbeef
8 00000150 000003fc cafef00d 00 0 00000000
4 00000154 000003fe 00000000 0d 1 0000cafe
1 00000158 000003fd 00000000 0e 1 fffffff0

//--- tests/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
        import mem_pkg::*;

        localparam int NUM_CASES = 23;
        localparam int COLS      = 7;          // Values per line of the case file
        localparam int WAIT_MAX  = 200;

        logic      clk;
        logic      rst;
        logic      ex_valid;
        word_t     ex_pc;
        mem_op_e   ex_op;
        word_t     ex_addr;
        word_t     ex_store_data;
        reg_addr_t ex_dest;
        logic      ex_gr_we;
        logic      wb_hold;
        logic      mem_allowin;
        logic      fwd_valid;
        reg_addr_t fwd_addr;
        word_t     fwd_data;
        logic      retire_valid;
        word_t     retire_pc;
        reg_addr_t retire_dest;
        logic      retire_we;
        word_t     retire_data;

        logic [31:0] case_words [COLS*NUM_CASES];
        logic [7:0]  model_mem [1024];         // Byte image of the 256-word RAM
        word_t       expect_data [NUM_CASES];
        bit          case_bad [NUM_CASES];
        int          order_q [$];              // Accepted, not yet retired
        int          n_pass;
        int          n_fail;
        int          n_err;
        int          n_retired;
        logic [31:0] rng;

        mem_subsys #(.READ_LATENCY(2)) dut_i (
                .clk           (clk),
                .rst           (rst),
                .ex_valid      (ex_valid),
                .ex_pc         (ex_pc),
                .ex_op         (ex_op),
                .ex_addr       (ex_addr),
                .ex_store_data (ex_store_data),
                .ex_dest       (ex_dest),
                .ex_gr_we      (ex_gr_we),
                .wb_hold       (wb_hold),
                .mem_allowin   (mem_allowin),
                .fwd_valid     (fwd_valid),
                .fwd_addr      (fwd_addr),
                .fwd_data      (fwd_data),
                .retire_valid  (retire_valid),
                .retire_pc     (retire_pc),
                .retire_dest   (retire_dest),
                .retire_we     (retire_we),
                .retire_data   (retire_data)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // ########################################
        // Random source and reference model
        // ########################################

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic word_t case_field(input int k, input int c);
                return case_words[k*COLS + c];
        endfunction

        task automatic model_apply(input mem_op_e op, input word_t a, input word_t sd,
                                   input reg_addr_t dest, output word_t res);
                logic [9:0]  b;
                logic [9:0]  h;
                logic [9:0]  w;
                logic [15:0] half;
                b    = a[9:0];
                h    = {a[9:1], 1'b0};
                w    = {a[9:2], 2'b00};
                half = {model_mem[h+1], model_mem[h]};
                res  = a;                      // ALU result unless a load replaces it
                case (op)
                op_ld_b:  res = {{24{model_mem[b][7]}}, model_mem[b]};
                op_ld_bu: res = {24'h0, model_mem[b]};
                op_ld_h:  res = {{16{half[15]}}, half};
                op_ld_hu: res = {16'h0, half};
                op_ld_w:  res = {model_mem[w+3], model_mem[w+2], model_mem[w+1], model_mem[w]};
                op_st_b:  model_mem[b] = sd[7:0];
                op_st_h: begin
                        model_mem[h]   = sd[7:0];
                        model_mem[h+1] = sd[15:8];
                end
                op_st_w: begin
                        for (int i = 0; i < 4; i++) begin
                                model_mem[w+i] = sd[8*i +: 8];
                        end
                end
                default: ;
                endcase
                if (dest == '0) res = '0;       // Register zero always reads zero
        endtask

        task automatic build_expected();
                word_t res;
                word_t dest;
                for (int k = 0; k < NUM_CASES; k++) begin
                        dest = case_field(k, 4);
                        model_apply(mem_op_e'(case_field(k, 0)), case_field(k, 2),
                                    case_field(k, 3), dest[4:0], res);
                        expect_data[k] = res;
                        if (case_field(k, 6) !== res) begin
                                $display("ERR case %0d retire_data in file 0x%08h model 0x%08h",
                                         k, case_field(k, 6), res);
                                n_err++;
                        end
                end
        endtask

        // ########################################
        // Stimulus and scoring
        // ########################################

        task automatic present_case(input int k);
                word_t dest;
                word_t we;
                dest          = case_field(k, 4);
                we            = case_field(k, 5);
                ex_valid      = 1'b1;
                ex_op         = mem_op_e'(case_field(k, 0));
                ex_pc         = case_field(k, 1);
                ex_addr       = case_field(k, 2);
                ex_store_data = case_field(k, 3);
                ex_dest       = dest[4:0];
                ex_gr_we      = we[0];
        endtask

        task automatic drive_hold();
                rng     = xorshift(rng);
                wb_hold = (rng[1:0] == 2'd0);
        endtask

        // The newest unretired instruction is the one held in the memory stage
        task automatic compare_forwarding();
                int      k;
                logic    want;
                word_t   we;
                word_t   dest;
                mem_op_e op;
                want = 1'b0;
                k    = -1;
                if (order_q.size() != 0) begin
                        k    = order_q[$];
                        op   = mem_op_e'(case_field(k, 0));
                        we   = case_field(k, 5);
                        want = (op == op_alu) && we[0];
                end
                if (fwd_valid !== want) begin
                        $display("ERR fwd_valid 0x%0h expected 0x%0h", fwd_valid, want);
                        if (k >= 0) case_bad[k] = 1'b1;
                        else n_err++;
                end else if (want) begin
                        dest = case_field(k, 4);
                        if (fwd_addr !== dest[4:0]) begin
                                $display("ERR fwd_addr 0x%02h expected 0x%02h",
                                         fwd_addr, dest[4:0]);
                                case_bad[k] = 1'b1;
                        end
                        if (fwd_data !== case_field(k, 2)) begin
                                $display("ERR fwd_data 0x%08h expected 0x%08h",
                                         fwd_data, case_field(k, 2));
                                case_bad[k] = 1'b1;
                        end
                end
        endtask

        task automatic score_retire();
                int      k;
                logic    bad;
                word_t   exp_pc;
                word_t   exp_dest;
                word_t   exp_we;
                mem_op_e op;
                if (order_q.size() == 0) begin
                        $display("retire_valid went high with no instruction outstanding");
                        n_err++;
                end else begin
                        k        = order_q.pop_front();
                        bad      = case_bad[k];
                        op       = mem_op_e'(case_field(k, 0));
                        exp_pc   = case_field(k, 1);
                        exp_dest = case_field(k, 4);
                        exp_we   = case_field(k, 5);
                        if (retire_pc !== exp_pc) begin
                                $display("ERR retire_pc 0x%08h expected 0x%08h",
                                         retire_pc, exp_pc);
                                bad = 1'b1;
                        end
                        if (retire_dest !== exp_dest[4:0]) begin
                                $display("ERR retire_dest 0x%02h expected 0x%02h",
                                         retire_dest, exp_dest[4:0]);
                                bad = 1'b1;
                        end
                        if (retire_we !== exp_we[0]) begin
                                $display("ERR retire_we 0x%0h expected 0x%0h", retire_we, exp_we[0]);
                                bad = 1'b1;
                        end
                        if (retire_data !== expect_data[k]) begin
                                $display("ERR retire_data 0x%08h expected 0x%08h",
                                         retire_data, expect_data[k]);
                                bad = 1'b1;
                        end
                        n_retired++;
                        if (bad) begin
                                n_fail++;
                                $display("case %0d %s pc 0x%08h: failed", k, op.name(), exp_pc);
                        end else begin
                                n_pass++;
                                $display("case %0d %s pc 0x%08h: ok", k, op.name(), exp_pc);
                        end
                end
        endtask

        initial begin
                forever begin
                        @(negedge clk);
                        if (!rst && retire_valid) score_retire();
                end
        end

        initial begin
                int gap;
                int waited;
                int chk_fails;
                bit timed_out;
                rng           = 32'h8142;
                rst           = 1'b1;
                ex_valid      = 1'b0;
                ex_pc         = '0;
                ex_op         = op_alu;
                ex_addr       = '0;
                ex_store_data = '0;
                ex_dest       = '0;
                ex_gr_we      = 1'b0;
                wb_hold       = 1'b0;
                n_pass        = 0;
                n_fail        = 0;
                n_err         = 0;
                n_retired     = 0;
                timed_out     = 1'b0;
                $readmemh("tests/mem_cases.txt", case_words);
                build_expected();
                repeat (8) @(negedge clk);
                rst = 1'b0;
                @(negedge clk);
                #1;
                if ((retire_valid !== 1'b0) || (fwd_valid !== 1'b0) ||
                    (mem_allowin !== 1'b1)) begin
                        $display("ERR retire_valid 0x%0h fwd_valid 0x%0h mem_allowin 0x%0h",
                                 retire_valid, fwd_valid, mem_allowin);
                        n_fail++;
                        $display("reset state: failed");
                end else begin
                        n_pass++;
                        $display("reset state: ok");
                end
                for (int k = 0; (k < NUM_CASES) && !timed_out; k++) begin
                        rng = xorshift(rng);
                        gap = rng[1:0];         // Idle cycles before the next instruction
                        repeat (gap) begin
                                @(negedge clk);
                                ex_valid = 1'b0;
                                drive_hold();
                                #1;
                                compare_forwarding();
                        end
                        @(negedge clk);
                        present_case(k);
                        drive_hold();
                        #1;
                        compare_forwarding();
                        waited = 0;
                        while (!mem_allowin && (waited < WAIT_MAX)) begin
                                @(negedge clk);
                                drive_hold();
                                #1;
                                compare_forwarding();
                                waited++;
                        end
                        if (!mem_allowin) begin
                                $display("Timeout while waiting for mem_allowin");
                                timed_out = 1'b1;
                        end else begin
                                @(posedge clk);         // Taken on this edge
                                order_q.push_back(k);
                        end
                end
                @(negedge clk);
                ex_valid = 1'b0;
                drive_hold();
                #1;
                compare_forwarding();
                waited = 0;
                while (!timed_out && (order_q.size() != 0) && (waited < WAIT_MAX)) begin
                        @(negedge clk);
                        drive_hold();
                        #1;
                        compare_forwarding();
                        waited++;
                end
                if (!timed_out && (order_q.size() != 0)) begin
                        $display("Timeout while waiting for retire_valid");
                        timed_out = 1'b1;
                end
                @(negedge clk);
                wb_hold = 1'b0;
                repeat (3) @(negedge clk);      // Any extra retire shows up here
                chk_fails = dut_i.mem_i.chk_i.assert_fails;
                $display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
                         NUM_CASES + 1, n_pass, n_fail, n_err, chk_fails);
                if (!timed_out && (n_fail == 0) && (n_err == 0) && (chk_fails == 0) &&
                    (n_retired == NUM_CASES)) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

//--- tests/mem_subsys_chk.sv
`timescale 1ns/1ps

module mem_subsys_chk (
        input logic                clk,
        input logic                rst,
        input mem_pkg::mem_state_e state,
        input mem_pkg::mem_op_e    op,
        input logic                en,
        input mem_pkg::be_t        we,
        input logic                ready,
        input logic                allowin,
        input logic                wb_allowin
);
        import mem_pkg::*;

        logic lanes_ok;
        int   assert_fails = 0;                 // Failed assertions so far

        always_comb begin
                case (op)
                op_st_b: lanes_ok = $onehot(we);
                op_st_h: lanes_ok = (we == 4'b0011) || (we == 4'b1100);
                op_st_w: lanes_ok = (we == 4'b1111);
                default: lanes_ok = (we == 4'b0000);   // Loads write nothing
                endcase
        end

        en_drops: assert property (@(posedge clk) disable iff (rst) ready |=> !en)
                else begin
                        $error("en still high in the cycle after ready");
                        assert_fails++;
                end

        store_lanes: assert property (@(posedge clk) disable iff (rst) en |-> lanes_ok)
                else begin
                        $error("lane enables %b do not fit operation %s", we, op.name());
                        assert_fails++;
                end

        // A blocked done instruction must not be replaced by a new one
        done_held: assert property (@(posedge clk) disable iff (rst)
                        (state == st_done) && !wb_allowin |=> (state == st_done) && $stable(op))
                else begin
                        $error("done instruction not held while writeback blocked");
                        assert_fails++;
                end

endmodule

bind mem_stage mem_subsys_chk chk_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .op         (op_q),
        .en         (dmem.en),
        .we         (dmem.we),
        .ready      (dmem.ready),
        .allowin    (allowin),
        .wb_allowin (wb_allowin)
);

//--- design/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys #(
        parameter int READ_LATENCY = 2
) (
        input  logic               clk,
        input  logic               rst,
        input  logic               ex_valid,
        input  mem_pkg::word_t     ex_pc,
        input  mem_pkg::mem_op_e   ex_op,
        input  mem_pkg::word_t     ex_addr,
        input  mem_pkg::word_t     ex_store_data,
        input  mem_pkg::reg_addr_t ex_dest,
        input  logic               ex_gr_we,
        input  logic               wb_hold,
        output logic               mem_allowin,
        output logic               fwd_valid,
        output mem_pkg::reg_addr_t fwd_addr,
        output mem_pkg::word_t     fwd_data,
        output logic               retire_valid,
        output mem_pkg::word_t     retire_pc,
        output mem_pkg::reg_addr_t retire_dest,
        output logic               retire_we,
        output mem_pkg::word_t     retire_data
);
        import mem_pkg::*;

        logic      wb_allowin;
        logic      ms_valid;
        word_t     ms_pc;
        reg_addr_t ms_dest;
        logic      ms_we;
        word_t     ms_data;

        dmem_if dmem ();

        mem_stage mem_i (
                .clk           (clk),
                .rst           (rst),
                .in_valid      (ex_valid),
                .in_pc         (ex_pc),
                .in_op         (ex_op),
                .in_addr       (ex_addr),
                .in_store_data (ex_store_data),
                .in_dest       (ex_dest),
                .in_gr_we      (ex_gr_we),
                .wb_allowin    (wb_allowin),
                .allowin       (mem_allowin),
                .dmem          (dmem.mem_stage),
                .fwd_valid     (fwd_valid),
                .fwd_addr      (fwd_addr),
                .fwd_data      (fwd_data),
                .out_valid     (ms_valid),
                .out_pc        (ms_pc),
                .out_dest      (ms_dest),
                .out_we        (ms_we),
                .out_data      (ms_data)
        );

        data_ram #(
                .READ_LATENCY (READ_LATENCY)
        ) ram_i (
                .clk (clk),
                .rst (rst),
                .bus (dmem.ram)
        );

        wb_stage wb_i (
                .clk          (clk),
                .rst          (rst),
                .hold         (wb_hold),
                .allowin      (wb_allowin),
                .in_valid     (ms_valid),
                .in_pc        (ms_pc),
                .in_dest      (ms_dest),
                .in_we        (ms_we),
                .in_data      (ms_data),
                .retire_valid (retire_valid),
                .retire_pc    (retire_pc),
                .retire_dest  (retire_dest),
                .retire_we    (retire_we),
                .retire_data  (retire_data)
        );

endmodule

//--- design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
        input  logic               clk,
        input  logic               rst,
        input  logic               hold,
        output logic               allowin,
        input  logic               in_valid,
        input  mem_pkg::word_t     in_pc,
        input  mem_pkg::reg_addr_t in_dest,
        input  logic               in_we,
        input  mem_pkg::word_t     in_data,
        output logic               retire_valid,
        output mem_pkg::word_t     retire_pc,
        output mem_pkg::reg_addr_t retire_dest,
        output logic               retire_we,
        output mem_pkg::word_t     retire_data
);
        import mem_pkg::*;

        logic      valid_q;
        word_t     pc_q;
        reg_addr_t dest_q;
        logic      we_q;
        word_t     data_q;

        assign allowin = ~hold;                 // Each entry leaves after one cycle

        always_ff @(posedge clk) begin
                if (rst) begin
                        valid_q <= 1'b0;
                end else begin
                        valid_q <= in_valid & allowin;
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid && allowin) begin
                        pc_q   <= in_pc;
                        dest_q <= in_dest;
                        we_q   <= in_we;
                        data_q <= in_data;
                end
        end

        assign retire_valid = valid_q;
        assign retire_pc    = pc_q;
        assign retire_dest  = dest_q;
        assign retire_we    = we_q;
        assign retire_data  = (dest_q == '0) ? '0 : data_q;

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
        parameter int READ_LATENCY = 2,
        parameter int DEPTH_WORDS  = 256
) (
        input  logic clk,
        input  logic rst,
        dmem_if.ram  bus
);
        import mem_pkg::*;

        localparam int AW    = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
        localparam int CNT_W = $clog2(READ_LATENCY + 1);

        word_t            mem [DEPTH_WORDS];
        logic [AW-1:0]    idx;
        logic [AW-1:0]    rd_idx;
        logic             armed;                // Request seen for one cycle
        logic [CNT_W-1:0] cnt;                  // Cycles left until read data
        logic             accept;

        assign idx    = AW'((bus.addr >> 2) % DEPTH_WORDS);
        assign accept = bus.en & armed & (cnt == '0);

        // ########################################
        // Acceptance and read latency
        // ########################################

        always_ff @(posedge clk) begin
                if (rst) begin
                        armed <= 1'b0;
                        cnt   <= '0;
                end else begin
                        armed <= bus.en & ~accept;
                        if (accept && (bus.we == 4'b0000)) begin
                                cnt <= CNT_W'(READ_LATENCY);
                        end else if (cnt != '0) begin
                                cnt <= cnt - 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        rd_idx <= idx;
                        for (int i = 0; i < 4; i++) begin
                                if (bus.we[i]) mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                        end
                end
        end

        assign bus.ready  = accept;             // One cycle after en rises
        assign bus.rvalid = (cnt == CNT_W'(1));
        assign bus.rdata  = mem[rd_idx];

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
        input  logic               clk,
        input  logic               rst,
        input  logic               in_valid,
        input  mem_pkg::word_t     in_pc,
        input  mem_pkg::mem_op_e   in_op,
        input  mem_pkg::word_t     in_addr,
        input  mem_pkg::word_t     in_store_data,
        input  mem_pkg::reg_addr_t in_dest,
        input  logic               in_gr_we,
        input  logic               wb_allowin,
        output logic               allowin,
        dmem_if.mem_stage          dmem,
        output logic               fwd_valid,
        output mem_pkg::reg_addr_t fwd_addr,
        output mem_pkg::word_t     fwd_data,
        output logic               out_valid,
        output mem_pkg::word_t     out_pc,
        output mem_pkg::reg_addr_t out_dest,
        output logic               out_we,
        output mem_pkg::word_t     out_data
);
        import mem_pkg::*;

        mem_state_e state;
        mem_state_e entry_state;
        logic       accept;
        logic       is_load;

        word_t      pc_q;
        mem_op_e    op_q;
        word_t      addr_q;
        word_t      sdata_q;
        reg_addr_t  dest_q;
        logic       gr_we_q;
        word_t      res_q;                      // ALU value, later the loaded value

        be_t        lanes;
        word_t      wdata_steer;
        word_t      load_ext;

        assign allowin     = (state == st_idle) | ((state == st_done) & wb_allowin);
        assign accept      = in_valid & allowin;
        assign entry_state = (in_op == op_alu) ? st_done : st_req;

        // ########################################
        // Stage sequencing
        // ########################################

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= st_idle;
                end else begin
                        case (state)
                        st_idle: if (in_valid) state <= entry_state;
                        st_req:  if (dmem.ready) state <= is_load ? st_wait : st_done;
                        st_wait: if (dmem.rvalid) state <= st_done;
                        st_done: if (wb_allowin) state <= in_valid ? entry_state : st_idle;
                        default: state <= st_idle;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        pc_q    <= in_pc;
                        op_q    <= in_op;
                        addr_q  <= in_addr;
                        sdata_q <= in_store_data;
                        dest_q  <= in_dest;
                        gr_we_q <= in_gr_we;
                        res_q   <= in_addr;
                end else if ((state == st_wait) && dmem.rvalid) begin
                        res_q   <= load_ext;    // Extended value taken with rvalid
                end
        end

        // ########################################
        // Store steering and load extension
        // ########################################

        always_comb begin
                is_load     = 1'b0;
                lanes       = 4'b0000;
                wdata_steer = sdata_q;
                case (op_q)
                op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w: is_load = 1'b1;
                op_st_b: begin
                        lanes       = 4'b0001 << addr_q[1:0];
                        wdata_steer = {4{sdata_q[7:0]}};
                end
                op_st_h: begin
                        lanes       = addr_q[1] ? 4'b1100 : 4'b0011;
                        wdata_steer = {2{sdata_q[15:0]}};
                end
                op_st_w: lanes = 4'b1111;
                default: ;
                endcase
        end

        always_comb begin
                logic [7:0]  byte_sel;
                logic [15:0] half_sel;
                byte_sel = dmem.rdata[{addr_q[1:0], 3'b000} +: 8];
                half_sel = addr_q[1] ? dmem.rdata[31:16] : dmem.rdata[15:0];
                case (op_q)
                op_ld_b:  load_ext = {{24{byte_sel[7]}}, byte_sel};
                op_ld_bu: load_ext = {24'b0, byte_sel};
                op_ld_h:  load_ext = {{16{half_sel[15]}}, half_sel};
                op_ld_hu: load_ext = {16'b0, half_sel};
                default:  load_ext = dmem.rdata;
                endcase
        end

        assign dmem.en    = (state == st_req);
        assign dmem.we    = dmem.en ? lanes : 4'b0000;
        assign dmem.addr  = addr_q;             // Low bits only pick lanes
        assign dmem.wdata = wdata_steer;

        // ########################################
        // Forwarding and writeback side
        // ########################################

        assign fwd_valid = (state != st_idle) & (op_q == op_alu) & gr_we_q;
        assign fwd_addr  = dest_q;
        assign fwd_data  = addr_q;

        assign out_valid = (state == st_done);  // Held until writeback takes it
        assign out_pc    = pc_q;
        assign out_dest  = dest_q;
        assign out_we    = gr_we_q;
        assign out_data  = res_q;

endmodule

//--- design/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;
        import mem_pkg::*;

        logic  en;                              // Request present
        be_t   we;                              // Store lanes, zero for a load
        word_t addr;
        word_t wdata;
        word_t rdata;
        logic  ready;                           // Acceptance pulse
        logic  rvalid;                          // Load data pulse

        modport mem_stage (
                output en,
                output we,
                output addr,
                output wdata,
                input  rdata,
                input  ready,
                input  rvalid
        );

        modport ram (
                input  en,
                input  we,
                input  addr,
                input  wdata,
                output rdata,
                output ready,
                output rvalid
        );

endinterface

//--- design/mem_pkg.sv
package mem_pkg;

        // ########################################
        // Widths
        // ########################################

        typedef logic [31:0] word_t;            // Data or address word
        typedef logic [3:0]  be_t;              // One bit per byte lane
        typedef logic [4:0]  reg_addr_t;        // Register number

        // ########################################
        // Operations and stage states
        // ########################################

        typedef enum logic [3:0] {
                op_alu   = 4'd0,                // Result passes through
                op_ld_b  = 4'd1,
                op_ld_bu = 4'd2,
                op_ld_h  = 4'd3,
                op_ld_hu = 4'd4,
                op_ld_w  = 4'd5,
                op_st_b  = 4'd6,
                op_st_h  = 4'd7,
                op_st_w  = 4'd8
        } mem_op_e;

        typedef enum logic [1:0] {
                st_idle = 2'd0,                 // Stage empty
                st_req  = 2'd1,                 // Request on the bus
                st_wait = 2'd2,                 // Load accepted, data pending
                st_done = 2'd3                  // Result ready for writeback
        } mem_state_e;

endpackage
